//--- invaders_mem_pkg.sv
`default_nettype none

package invaders_mem_pkg;

	// CPU side address and data
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] byte_t;

	// Offsets inside the 8 KB ROM image and the 8 KB RAM
	typedef logic [12:0] rom_addr_t;
	typedef logic [12:0] ram_addr_t;

	// ROM bank number, address bits 12:11
	typedef logic [1:0] bank_sel_t;

	// Tag of a read in flight
	typedef enum logic {
		src_rom,
		src_ram
	} rsp_src_t;

	// Bit 13 splits ROM (0x0000) from RAM (0x2000); bits 15:14 only mirror
	localparam int RAM_SEL_BIT = 13;

endpackage

`default_nettype wire

//--- mem_port_if.sv
`default_nettype none

interface mem_port_if
	import invaders_mem_pkg::*;
#(
	parameter int ADDR_W = 11
);

	logic rd_en;
	logic wr_en;
	logic [ADDR_W-1:0] addr;
	byte_t wdata;
	byte_t rdata; // Valid the clock after rd_en

	modport decoder (
		output rd_en,
		output wr_en,
		output addr,
		output wdata
	);

	modport memory (
		input  rd_en,
		input  wr_en,
		input  addr,
		input  wdata,
		output rdata
	);

	modport collector (
		input  rdata
	);

endinterface

`default_nettype wire

//--- mem_decoder.sv
`default_nettype none

module mem_decoder
	import invaders_mem_pkg::*;
#(
	parameter int NUM_BANKS = 4,
	parameter int BANK_AW = 11,
	parameter int RAM_AW = 13
) (
	input  logic clock,
	input  logic rst_n,

	input  logic req_valid,
	input  logic req_we,
	input  cpu_addr_t req_addr,
	input  byte_t req_wdata,
	output logic req_ready,

	input  logic dn_wr,
	input  rom_addr_t dn_addr,
	input  byte_t dn_data,

	input  logic slot_free,
	output logic rd_issue,
	output rsp_src_t rd_src,
	output bank_sel_t rd_bank,

	mem_port_if.decoder bank_port [NUM_BANKS],
	mem_port_if.decoder ram_port
);

	logic rst_done;
	logic acc;
	logic is_ram;
	logic cpu_rd;
	bank_sel_t cpu_bank;
	bank_sel_t dn_bank;
	ram_addr_t ram_off;

	// Hold off requests until out of reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rst_done <= 1'b0;
		else
			rst_done <= 1'b1;
	end

	assign req_ready = slot_free && !dn_wr && rst_done; // Download wins
	assign acc = req_valid && req_ready;

	// Bits 15:14 never looked at, map mirrors every 16 KB
	assign is_ram = req_addr[RAM_SEL_BIT];
	assign cpu_bank = req_addr[RAM_SEL_BIT-1 -: $bits(bank_sel_t)];
	assign dn_bank = dn_addr[$bits(rom_addr_t)-1 -: $bits(bank_sel_t)];
	assign ram_off = req_addr[RAM_SEL_BIT-1:0];
	assign cpu_rd = acc && !req_we;

	// Read tag towards the collector
	assign rd_issue = cpu_rd;
	assign rd_src = is_ram ? src_ram : src_rom;
	assign rd_bank = cpu_bank;

	// ROM banks, only the download port writes them
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		assign bank_port[i].wr_en = dn_wr && (dn_bank == bank_sel_t'(i));
		assign bank_port[i].rd_en = cpu_rd && !is_ram && (cpu_bank == bank_sel_t'(i));
		assign bank_port[i].addr = dn_wr ? dn_addr[BANK_AW-1:0] : req_addr[BANK_AW-1:0];
		assign bank_port[i].wdata = dn_data;
	end

	// CPU writes to ROM fall through here and are dropped
	assign ram_port.rd_en = cpu_rd && is_ram;
	assign ram_port.wr_en = acc && req_we && is_ram; // No response for writes
	assign ram_port.addr = ram_off[RAM_AW-1:0];
	assign ram_port.wdata = req_wdata;

endmodule

`default_nettype wire

//--- rom_bank.sv
`default_nettype none

module rom_bank
	import invaders_mem_pkg::*;
#(
	parameter int BANK_AW = 11
) (
	input  logic clock,
	mem_port_if.memory port
);

	byte_t mem [2**BANK_AW];

	// Loaded once at boot from the download path
	always_ff @(posedge clock) begin
		if (port.wr_en)
			mem[port.addr] <= port.wdata;
	end

	always_ff @(posedge clock) begin
		if (port.rd_en)
			port.rdata <= mem[port.addr]; // One cycle read
	end

endmodule

`default_nettype wire

//--- work_ram.sv
`default_nettype none

module work_ram
	import invaders_mem_pkg::*;
#(
	parameter int RAM_AW = 13
) (
	input  logic clock,
	mem_port_if.memory port
);

	// Work RAM and the 1 bpp frame buffer share this array
	byte_t mem [2**RAM_AW];

	always_ff @(posedge clock) begin
		if (port.wr_en)
			mem[port.addr] <= port.wdata;
	end

	always_ff @(posedge clock) begin
		if (port.rd_en) begin
			if (port.wr_en)
				port.rdata <= port.wdata; // Write-first
			else
				port.rdata <= mem[port.addr];
		end
	end

endmodule

`default_nettype wire

//--- read_collector.sv
`default_nettype none

module read_collector
	import invaders_mem_pkg::*;
#(
	parameter int NUM_BANKS = 4
) (
	input  logic clock,
	input  logic rst_n,

	input  logic rd_issue,
	input  rsp_src_t rd_src,
	input  bank_sel_t rd_bank,

	mem_port_if.collector bank_port [NUM_BANKS],
	mem_port_if.collector ram_port,

	output logic slot_free,
	output logic rsp_valid,
	output byte_t rsp_data,
	input  logic rsp_ready
);

	byte_t bank_rdata [NUM_BANKS];
	logic rd_pend;
	rsp_src_t src_q;
	bank_sel_t bank_q;
	byte_t sel_data;
	byte_t q_data [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic push;
	logic pop;

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_rdata
		assign bank_rdata[i] = bank_port[i].rdata;
	end

	// Tag lines up with the registered read data
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rd_pend <= 1'b0;
		else
			rd_pend <= rd_issue;
	end

	always_ff @(posedge clock) begin
		if (rd_issue) begin
			src_q <= rd_src;
			bank_q <= rd_bank;
		end
	end

	always_comb begin
		sel_data = bank_rdata[bank_q];
		if (src_q == src_ram)
			sel_data = ram_port.rdata;
	end

	// Returning byte goes straight out when the queue is empty and taken
	assign push = rd_pend && !(rsp_ready && count == 2'd0);
	assign pop = rsp_ready && (count != 2'd0);

	// Two entry response queue
	always_ff @(posedge clock) begin
		if (push)
			q_data[wr_ptr] <= sel_data;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	assign rsp_valid = (count != 2'd0) || rd_pend;
	assign rsp_data = (count != 2'd0) ? q_data[rd_ptr] : sel_data; // Head holds until popped

	// Queued plus in flight must leave room for one more
	assign slot_free = (count + {1'b0, rd_pend}) < 2'd2;

endmodule

`default_nettype wire

//--- invaders_memory.sv
`default_nettype none

module invaders_memory
	import invaders_mem_pkg::*;
#(
	parameter int NUM_BANKS = 4,
	parameter int BANK_AW = 11,
	parameter int RAM_AW = 13
) (
	input  logic clock,
	input  logic rst_n,

	// CPU request
	input  logic req_valid,
	output logic req_ready,
	input  logic req_we,
	input  cpu_addr_t req_addr,
	input  byte_t req_wdata,

	// Read response
	output logic rsp_valid,
	input  logic rsp_ready,
	output byte_t rsp_data,

	// ROM download at boot
	input  logic dn_wr,
	input  rom_addr_t dn_addr,
	input  byte_t dn_data
);

	logic slot_free;
	logic rd_issue;
	rsp_src_t rd_src;
	bank_sel_t rd_bank;

	mem_port_if #(.ADDR_W(BANK_AW)) bank_port [NUM_BANKS] ();
	mem_port_if #(.ADDR_W(RAM_AW)) ram_port ();

	mem_decoder #(
		.NUM_BANKS(NUM_BANKS),
		.BANK_AW(BANK_AW),
		.RAM_AW(RAM_AW)
	) u_decoder (
		.clock(clock),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_we(req_we),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.dn_wr(dn_wr),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.slot_free(slot_free),
		.rd_issue(rd_issue),
		.rd_src(rd_src),
		.rd_bank(rd_bank),
		.bank_port(bank_port),
		.ram_port(ram_port)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		rom_bank #(
			.BANK_AW(BANK_AW)
		) u_rom (
			.clock(clock),
			.port(bank_port[i])
		);
	end

	work_ram #(
		.RAM_AW(RAM_AW)
	) u_ram (
		.clock(clock),
		.port(ram_port)
	);

	read_collector #(
		.NUM_BANKS(NUM_BANKS)
	) u_collector (
		.clock(clock),
		.rst_n(rst_n),
		.rd_issue(rd_issue),
		.rd_src(rd_src),
		.rd_bank(rd_bank),
		.bank_port(bank_port),
		.ram_port(ram_port),
		.slot_free(slot_free),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_ready(rsp_ready)
	);

endmodule

`default_nettype wire

//--- invaders_memory_props.sv
`default_nettype none

module invaders_memory_props
	import invaders_mem_pkg::*;
(
	input logic clock,
	input logic rst_n,
	input logic req_valid,
	input logic req_ready,
	input logic req_we,
	input logic dn_wr,
	input logic rsp_valid,
	input logic rsp_ready,
	input byte_t rsp_data
);
	timeunit 1ns;
	timeprecision 100ps;

	int assert_fails = 0;

	rsp_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else begin
			$error("response changed while stalled");
			assert_fails++;
		end

	dn_blocks_req: assert property (@(posedge clock) disable iff (!rst_n)
		dn_wr |-> !req_ready)
		else begin
			$error("req_ready high during a download write");
			assert_fails++;
		end

	read_latency: assert property (@(posedge clock) disable iff (!rst_n)
		req_valid && req_ready && !req_we && !rsp_valid |=> rsp_valid)
		else begin
			$error("read on an empty queue gave no response one cycle later");
			assert_fails++;
		end

	reset_idle: assert property (@(posedge clock) !rst_n |-> !rsp_valid) // Queue cleared
		else begin
			$error("rsp_valid high in reset");
			assert_fails++;
		end

endmodule

bind invaders_memory invaders_memory_props u_props (.*);

`default_nettype wire

//--- tb_invaders_memory.sv
`default_nettype none

module tb_invaders_memory
	import invaders_mem_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 4;
	localparam logic [31:0] SEED = 32'h6446_ae68;
	localparam int N_DL = 8192;
	localparam int N_RD = 200;
	localparam int TOTAL_OPS = N_DL + 10 * N_RD;

	logic clock = 1'b0;
	logic rst_n;
	logic req_valid, req_ready, req_we;
	cpu_addr_t req_addr;
	byte_t req_wdata;
	logic rsp_valid, rsp_ready;
	byte_t rsp_data;
	logic dn_wr;
	rom_addr_t dn_addr;
	byte_t dn_data;

	logic [31:0] seed = SEED;
	logic [31:0] stall_seed = SEED ^ 32'h5555_5555;
	logic stall_en = 1'b0;
	rom_addr_t last_dn;
	byte_t rom_model [8192];
	byte_t ram_model [8192];
	bit ram_written [8192];
	logic [8:0] exp_q [$]; // Check flag and expected byte
	int errors = 0;
	int checks = 0;

	invaders_memory dut (.*);

	always #(PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu_addr_t rand_addr();
		seed = lcg(seed);
		return seed[31:16];
	endfunction

	function automatic byte_t rand_byte();
		seed = lcg(seed);
		return seed[31:24];
	endfunction

	// Called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic cpu_op(input logic we, input cpu_addr_t a, input byte_t d, input logic with_dn);
		req_valid = 1'b1;
		req_we = we;
		req_addr = a;
		req_wdata = d;
		if (with_dn) begin
			dn_wr = 1'b1;
			dn_addr = rom_addr_t'(rand_addr());
			last_dn = dn_addr;
			dn_data = rand_byte();
		end
		@(negedge clock);
		while (!req_ready) begin
			@(posedge clock);
			#1 dn_wr = 1'b0;
			@(negedge clock);
		end
		@(posedge clock);
		#1 req_valid = 1'b0;
		dn_wr = 1'b0;
	endtask

	always @(posedge clock) begin
		#1;
		stall_seed = lcg(stall_seed);
		rsp_ready = stall_en ? (stall_seed[31:29] > 3'd4) : 1'b1;
	end

	// Reference model, updated where inputs and outputs are settled
	always @(negedge clock) begin
		logic [8:0] head;
		if (rst_n) begin
			assert (!(exp_q.size() >= 2 && req_ready)) else begin
				$display("req_ready stayed high with two reads outstanding at %0t", $time);
				errors++;
			end
			if (dn_wr)
				rom_model[dn_addr] = dn_data;
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("response arrived with no read outstanding at %0t", $time);
					errors++;
				end else begin
					head = exp_q.pop_front();
					checks++;
					if (head[8])
						assert (rsp_data === head[7:0]) else begin
							$display("mismatch at %0t: rsp_data expected %02h received %02h",
								$time, head[7:0], rsp_data);
							errors++;
						end
				end
			end
			if (req_valid && req_ready) begin
				if (req_we && req_addr[13]) begin
					ram_model[req_addr[12:0]] = req_wdata;
					ram_written[req_addr[12:0]] = 1'b1;
				end else if (!req_we && req_addr[13])
					exp_q.push_back({ram_written[req_addr[12:0]], ram_model[req_addr[12:0]]});
				else if (!req_we)
					exp_q.push_back({1'b1, rom_model[req_addr[12:0]]});
			end
		end
	end

	initial begin : stimulus
		cpu_addr_t a;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_we = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b1;
		dn_wr = 1'b0;
		dn_addr = '0;
		dn_data = '0;
		repeat (8) @(posedge clock);
		#1 rst_n = 1'b1;
		for (int i = 0; i < N_DL; i++) begin // Full ROM image
			dn_wr = 1'b1;
			dn_addr = rom_addr_t'(i);
			dn_data = rand_byte();
			@(posedge clock);
			#1;
		end
		dn_wr = 1'b0;
		for (int i = 0; i < N_RD; i++)
			cpu_op(1'b0, rand_addr() & 16'h1fff, 8'h00, 1'b0);
		for (int i = 0; i < N_RD; i++) begin
			a = 16'h2000 | (rand_addr() & 16'h003f); // Small range so reads hit writes
			cpu_op(1'b1, a, rand_byte(), 1'b0);
			cpu_op(1'b0, a, 8'h00, 1'b0);
			cpu_op(1'b0, 16'h2000 | (rand_addr() & 16'h003f), 8'h00, 1'b0);
		end
		for (int i = 0; i < N_RD; i++) begin
			a = rand_addr() & 16'hdfff;
			cpu_op(1'b1, a, rand_byte(), 1'b0); // Dropped by the decoder
			cpu_op(1'b0, a ^ 16'hc000, 8'h00, 1'b0);
			cpu_op(1'b0, (rand_addr() & 16'hc03f) | 16'h2000, 8'h00, 1'b0);
		end
		stall_en = 1'b1;
		for (int i = 0; i < N_RD; i++)
			cpu_op(1'b0, rand_addr() & 16'h1fff, 8'h00, 1'b0);
		stall_en = 1'b0;
		for (int i = 0; i < N_RD; i++) begin
			cpu_op(1'b0, rand_addr() & 16'h1fff, 8'h00, 1'b1);
			cpu_op(1'b0, {2'b01, 1'b0, last_dn}, 8'h00, 1'b0);
		end
		while (exp_q.size() != 0)
			@(negedge clock);
		repeat (4) @(posedge clock);
		$display("responses checked %0d, errors %0d, assertion failures %0d",
			checks, errors, dut.u_props.assert_fails);
		if (errors == 0 && dut.u_props.assert_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : watchdog
		#(TOTAL_OPS * 20 * PERIOD);
		$display("run timed out before all operations completed");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- invaders_memory.f
invaders_mem_pkg.sv
mem_port_if.sv
mem_decoder.sv
rom_bank.sv
work_ram.sv
read_collector.sv
invaders_memory.sv
invaders_memory_props.sv
tb_invaders_memory.sv

//--- Bender.yml
package:
  name: invaders_memory

sources:
  - invaders_mem_pkg.sv
  - mem_port_if.sv
  - mem_decoder.sv
  - rom_bank.sv
  - work_ram.sv
  - read_collector.sv
  - invaders_memory.sv
  - target: test
    files:
      - invaders_memory_props.sv
      - tb_invaders_memory.sv
